// File: common/trace_pkg.sv
package trace_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int xlen       = 32;  // pc and register values
  localparam int stream_w   = 32;  // one stream word
  localparam int reg_addr_w = 5;

  ////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////

  // header is dst mac, src mac, ethertype, tag, lowest word first
  localparam int hdr_words     = 5;
  localparam int payload_words = 4;  // pc, instr, flags, gpr value
  localparam int frame_words   = hdr_words + payload_words;

  localparam logic [15:0] ethertype_trace = 16'h005c;

  localparam logic [47:0] board_mac = 48'h1654_1111_6843;
  localparam logic [47:0] host_mac  = 48'h8f54_0000_4502;

  // tags are ascii, byte reversed so the first character goes out first
  localparam logic [47:0] tag_trace   = 48'h7265_6361_7274;  // "tracer"
  localparam logic [47:0] tag_trigger = 48'h6e69_6769_7274;  // "trigin"
  localparam logic [47:0] tag_slow    = 48'h656d_776f_6c73;  // "slowme"

  // board to host
  localparam logic [hdr_words*stream_w-1:0] trace_header = {
    tag_trace, ethertype_trace, board_mac, host_mac
  };

  // host to board, matched on the receive side
  localparam logic [hdr_words*stream_w-1:0] trigger_pattern = {
    tag_trigger, ethertype_trace, host_mac, board_mac
  };

  localparam logic [hdr_words*stream_w-1:0] slow_pattern = {
    tag_slow, ethertype_trace, host_mac, board_mac
  };

  ////////////////////////////////////////
  // host slowdown
  ////////////////////////////////////////

  localparam int stall_cnt_w = 16;

endpackage

// File: trace/trace_capture.sv
module trace_capture (
  input  logic                           clk,
  input  logic                           arst_n,
  // retire port from the core
  input  logic                           retire_valid,
  input  logic [trace_pkg::xlen-1:0]     pc,
  input  logic [31:0]                    instr,
  input  logic                           trap,
  input  logic                           gpr_wen,
  input  logic [trace_pkg::reg_addr_w-1:0] gpr_addr,
  input  logic [trace_pkg::xlen-1:0]     gpr_value,
  // buffered record to the packetizer
  input  logic                           rec_take,
  output logic                           rec_valid,
  output logic [trace_pkg::xlen-1:0]     rec_pc,
  output logic [31:0]                    rec_instr,
  output logic                           rec_trap,
  output logic                           rec_gpr_wen,
  output logic [trace_pkg::reg_addr_w-1:0] rec_gpr_addr,
  output logic [trace_pkg::xlen-1:0]     rec_gpr_value,
  output logic                           trace_stall
);

  logic full;

  // retire wins, the core cannot retire into a full buffer anyway
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else if (retire_valid) begin
      full <= 1'b1;
    end else if (rec_take) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (retire_valid) begin
      rec_pc        <= pc;
      rec_instr     <= instr;
      rec_trap      <= trap;
      rec_gpr_wen   <= gpr_wen;
      rec_gpr_addr  <= gpr_addr;
      rec_gpr_value <= gpr_value;
    end
  end

  assign rec_valid   = full;
  assign trace_stall = full;  // hold the core until the slot drains

endmodule

// File: trace/trace_packetizer.sv
module trace_packetizer (
  input  logic                           clk,
  input  logic                           arst_n,
  // record from the capture buffer
  input  logic                           rec_valid,
  input  logic [trace_pkg::xlen-1:0]     rec_pc,
  input  logic [31:0]                    rec_instr,
  input  logic                           rec_trap,
  input  logic                           rec_gpr_wen,
  input  logic [trace_pkg::reg_addr_w-1:0] rec_gpr_addr,
  input  logic [trace_pkg::xlen-1:0]     rec_gpr_value,
  output logic                           rec_take,
  // transmit stream
  output logic [trace_pkg::stream_w-1:0] tx_data,
  output logic                           tx_valid,
  output logic                           tx_last,
  input  logic                           tx_ready
);

  import trace_pkg::*;

  logic                          busy;
  logic [$clog2(frame_words)-1:0] cnt;  // word index within the frame
  logic                          fire;

  // local copy of the record being sent
  logic [xlen-1:0]       pc_q;
  logic [31:0]           instr_q;
  logic                  trap_q;
  logic                  gpr_wen_q;
  logic [reg_addr_w-1:0] gpr_addr_q;
  logic [xlen-1:0]       gpr_value_q;

  assign fire     = tx_valid & tx_ready;
  assign tx_valid = busy;
  assign tx_last  = (cnt == frame_words - 1);

  // take when idle, or right as the last word leaves
  assign rec_take = rec_valid & (~busy | (fire & tx_last));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else begin
      if (rec_take) begin
        busy <= 1'b1;
      end else if (fire && tx_last) begin
        busy <= 1'b0;
      end
      if (fire) begin
        cnt <= tx_last ? '0 : cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rec_take) begin
      pc_q        <= rec_pc;
      instr_q     <= rec_instr;
      trap_q      <= rec_trap;
      gpr_wen_q   <= rec_gpr_wen;
      gpr_addr_q  <= rec_gpr_addr;
      gpr_value_q <= rec_gpr_value;
    end
  end

  ////////////////////////////////////////
  // word select
  ////////////////////////////////////////

  always_comb begin
    case (cnt)
      hdr_words:     tx_data = pc_q;
      hdr_words + 1: tx_data = instr_q;
      hdr_words + 2: tx_data = {23'b0, trap_q, 2'b0, gpr_wen_q, gpr_addr_q};  // flags
      hdr_words + 3: tx_data = gpr_value_q;
      default:       tx_data = trace_header[cnt*stream_w +: stream_w];
    endcase
  end

endmodule

// File: host/frame_matcher.sv
module frame_matcher #(
  parameter logic [trace_pkg::hdr_words*trace_pkg::stream_w-1:0] pattern =
    trace_pkg::trigger_pattern
) (
  input  logic                           clk,
  input  logic                           arst_n,
  // receive stream, always accepted
  input  logic [trace_pkg::stream_w-1:0] rx_data,
  input  logic                           rx_valid,
  input  logic                           rx_last,
  output logic                           hit,
  output logic [trace_pkg::stream_w-1:0] msg
);

  import trace_pkg::*;

  logic [$clog2(frame_words)-1:0] idx;  // saturates past the message word
  logic                          mismatch;
  logic                          word_bad;

  // only header words are compared
  assign word_bad = (idx < hdr_words) && (rx_data != pattern[idx*stream_w +: stream_w]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idx      <= '0;
      mismatch <= 1'b0;
      hit      <= 1'b0;
    end else begin
      hit <= 1'b0;
      if (rx_valid) begin
        if (rx_last) begin
          // idx at or past hdr_words means the message word is in
          hit      <= ~mismatch & (idx >= hdr_words);
          idx      <= '0;
          mismatch <= 1'b0;
        end else begin
          mismatch <= mismatch | word_bad;
          if (idx <= hdr_words) begin
            idx <= idx + 1'b1;
          end
        end
      end
    end
  end

  // sixth word of the frame
  always_ff @(posedge clk) begin
    if (rx_valid && idx == hdr_words) begin
      msg <= rx_data;
    end
  end

endmodule

// File: host/host_stall_timer.sv
module host_stall_timer (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           hit,
  input  logic [trace_pkg::stream_w-1:0] msg,
  output logic                           host_stall
);

  import trace_pkg::*;

  logic [stall_cnt_w-1:0] cnt;

  // a new hit reloads, even mid count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (hit) begin
      cnt <= msg[stall_cnt_w-1:0];  // upper bits ignored
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign host_stall = (cnt != '0);

endmodule

// File: verilog/trace_link_top.sv
module trace_link_top (
  input  logic                           clk,
  input  logic                           arst_n,
  // retire port
  input  logic                           retire_valid,
  input  logic [trace_pkg::xlen-1:0]     pc,
  input  logic [31:0]                    instr,
  input  logic                           trap,
  input  logic                           gpr_wen,
  input  logic [trace_pkg::reg_addr_w-1:0] gpr_addr,
  input  logic [trace_pkg::xlen-1:0]     gpr_value,
  // transmit stream to the host
  output logic [trace_pkg::stream_w-1:0] tx_data,
  output logic                           tx_valid,
  output logic                           tx_last,
  input  logic                           tx_ready,
  // receive stream from the host
  input  logic [trace_pkg::stream_w-1:0] rx_data,
  input  logic                           rx_valid,
  input  logic                           rx_last,
  output logic                           trigger,
  output logic                           ext_stall
);

  import trace_pkg::*;

  logic                  rec_valid, rec_take;
  logic [xlen-1:0]       rec_pc, rec_gpr_value;
  logic [31:0]           rec_instr;
  logic                  rec_trap, rec_gpr_wen;
  logic [reg_addr_w-1:0] rec_gpr_addr;
  logic                  trace_stall, host_stall;
  logic                  slow_hit;
  logic [stream_w-1:0]   slow_msg;

  ////////////////////////////////////////
  // trace path
  ////////////////////////////////////////

  trace_capture u_capture (
    .clk, .arst_n, .retire_valid, .pc, .instr, .trap, .gpr_wen, .gpr_addr, .gpr_value,
    .rec_take, .rec_valid, .rec_pc, .rec_instr, .rec_trap, .rec_gpr_wen, .rec_gpr_addr,
    .rec_gpr_value, .trace_stall
  );

  trace_packetizer u_packetizer (
    .clk, .arst_n, .rec_valid, .rec_pc, .rec_instr, .rec_trap, .rec_gpr_wen, .rec_gpr_addr,
    .rec_gpr_value, .rec_take, .tx_data, .tx_valid, .tx_last, .tx_ready
  );

  ////////////////////////////////////////
  // host requests
  ////////////////////////////////////////

  // both matchers listen to the same stream
  frame_matcher #(.pattern(trigger_pattern)) trigger_match (
    .clk, .arst_n, .rx_data, .rx_valid, .rx_last, .hit(trigger), .msg()
  );

  frame_matcher #(.pattern(slow_pattern)) slow_match (
    .clk, .arst_n, .rx_data, .rx_valid, .rx_last, .hit(slow_hit), .msg(slow_msg)
  );

  host_stall_timer u_stall_timer (
    .clk, .arst_n, .hit(slow_hit), .msg(slow_msg), .host_stall
  );

  assign ext_stall = trace_stall | host_stall;  // either source holds the core

endmodule

// File: bench/trace_link_assertions.sv
module trace_link_assertions (
  input logic                           clk, arst_n,
  input logic [trace_pkg::stream_w-1:0] tx_data, slow_msg,
  input logic                           tx_valid, tx_ready, tx_last, rx_valid, rx_last,
  input logic                           trigger, ext_stall, trace_stall, slow_hit
);

  timeunit 1ns;
  timeprecision 100ps;
  import trace_pkg::*;

  int                     fail_cnt = 0;
  logic [3:0]             words;  // accepted words since the last tx_last
  logic                   armed;  // a slowdown hit has been seen
  logic [stall_cnt_w-1:0] m_q;
  logic [stall_cnt_w:0]   since;  // cycles since that hit, saturating

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      words <= '0;
    end else if (tx_valid && tx_ready) begin
      words <= tx_last ? '0 : words + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      armed <= 1'b0;
      m_q   <= '0;
      since <= '0;
    end else if (slow_hit) begin
      armed <= 1'b1;
      m_q   <= slow_msg[stall_cnt_w-1:0];
      since <= 1;  // first stalled cycle follows the hit
    end else if (since != '1) begin
      since <= since + 1'b1;
    end
  end

  ////////////////////////////////////////
  // reset and transmit stream
  ////////////////////////////////////////

  a_reset: assert property (@(posedge clk)
    (!arst_n || $past(!arst_n)) |-> (!tx_valid && !trigger && !ext_stall))
    else begin
      $error("tx_valid, trigger or ext_stall high in or right after reset");
      fail_cnt++;
    end

  a_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_last)))
    else begin
      $error("transmit word changed while tx_ready was low");
      fail_cnt++;
    end

  a_length: assert property (@(posedge clk) disable iff (!arst_n)
    (tx_valid && tx_ready) |-> (tx_last == (words == 4'(frame_words - 1))))
    else begin
      $error("tx_last not on the ninth word of a frame");
      fail_cnt++;
    end

  // a waiting record goes out right behind the current frame
  a_back_to_back: assert property (@(posedge clk) disable iff (!arst_n)
    (tx_valid && tx_ready && tx_last && trace_stall) |=> tx_valid)
    else begin
      $error("gap between frames although a record was waiting");
      fail_cnt++;
    end

  a_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (trace_stall && tx_valid && !(tx_ready && tx_last)) |=> trace_stall)
    else begin
      $error("stall dropped while two records were in flight");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // host requests
  ////////////////////////////////////////

  a_trigger_pos: assert property (@(posedge clk) disable iff (!arst_n)
    trigger |-> $past(rx_valid && rx_last))
    else begin
      $error("trigger pulse not in the cycle after rx_last");
      fail_cnt++;
    end

  a_trigger_len: assert property (@(posedge clk) disable iff (!arst_n)
    trigger |=> !trigger)
    else begin
      $error("trigger pulse longer than one cycle");
      fail_cnt++;
    end

  // with the trace path idle, ext_stall covers exactly the m cycles after the hit
  a_slowdown: assert property (@(posedge clk) disable iff (!arst_n)
    !trace_stall |-> (ext_stall == (armed && since <= {1'b0, m_q})))
    else begin
      $error("host stall length differs from the requested cycle count");
      fail_cnt++;
    end

endmodule

bind trace_link_top trace_link_assertions checks (.*);

// File: bench/tb_top.sv
module tb_top;

  timeunit 1ns;
  timeprecision 100ps;
  import trace_pkg::*;

  localparam int n_retire   = 20;
  localparam int run_cycles = 8 + n_retire * (2 * frame_words + 4)
                              + n_retire * 8 * frame_words + 1000;

  logic                  clk, arst_n;
  logic                  retire_valid, trap, gpr_wen;
  logic [xlen-1:0]       pc, gpr_value;
  logic [31:0]           instr;
  logic [reg_addr_w-1:0] gpr_addr;
  logic [stream_w-1:0]   tx_data, rx_data;
  logic                  tx_valid, tx_last, tx_ready, rx_valid, rx_last, trigger, ext_stall;

  int                  seed = 85664;
  int                  err_cnt = 0;
  int                  test_cnt = 0;
  int                  err_mark = 0;
  int                  word_idx = 0;  // position in the current outgoing frame
  int                  trig_seen = 0;
  string               test_name;
  logic [stream_w-1:0] exp_q[$];  // expected transmit words

  trace_link_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // scoreboard, sampled mid cycle
  ////////////////////////////////////////

  always @(negedge clk) begin : monitor
    logic [stream_w-1:0] want;
    if (trigger) trig_seen++;
    if (tx_valid && tx_ready) begin
      if (exp_q.size() == 0) begin
        $display("%s: word %h sent with no retired record pending", test_name, tx_data);
        err_cnt++;
      end else begin
        want = exp_q.pop_front();
        if (tx_data !== want) begin
          $display("FAIL %s word %0d expected %h actual %h", test_name, word_idx, want, tx_data);
          err_cnt++;
        end
        if (tx_last !== (word_idx == frame_words - 1)) begin
          $display("FAIL %s tx_last at word %0d expected %0b actual %0b", test_name, word_idx,
                   word_idx == frame_words - 1, tx_last);
          err_cnt++;
        end
      end
      word_idx = (word_idx == frame_words - 1) ? 0 : word_idx + 1;
    end
  end

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = err_cnt + dut.checks.fail_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("%s done, %0d errors", test_name, err_cnt + dut.checks.fail_cnt - err_mark);
  endtask

  task automatic check_count(input string what, input int want, input int got);
    if (got != want) begin
      $display("FAIL %s %s expected %0d actual %0d", test_name, what, want, got);
      err_cnt++;
    end
  endtask

  // one retire strobe with a random record, expected frame queued
  task automatic retire_one();
    logic [stream_w-1:0] flags;
    retire_valid = 1'b1;
    pc           = $random(seed);
    instr        = $random(seed);
    trap         = 1'($random(seed));
    gpr_wen      = 1'($random(seed));
    gpr_addr     = 5'($random(seed));
    gpr_value    = $random(seed);
    flags        = '0;
    flags[8]     = trap;
    flags[5]     = gpr_wen;
    flags[4:0]   = gpr_addr;
    for (int i = 0; i < hdr_words; i++) begin
      exp_q.push_back(trace_header[i*stream_w +: stream_w]);
    end
    exp_q.push_back(pc);
    exp_q.push_back(instr);
    exp_q.push_back(flags);
    exp_q.push_back(gpr_value);
  endtask

  task automatic run_trace(input string name, input bit back_pressure);
    int done_n;
    done_n = 0;
    start_test(name);
    while (done_n < n_retire || exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      retire_valid = 1'b0;
      if (back_pressure) tx_ready = 1'($random(seed));
      if (done_n < n_retire && !ext_stall && ($random(seed) & 1) == 1) begin
        retire_one();
        done_n++;
      end
    end
    tx_ready = 1'b1;
    end_test();
  endtask

  task automatic send_frame(input logic [hdr_words*stream_w-1:0] hdr, input int len,
                            input logic [stream_w-1:0] m);
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      #1;
      rx_valid = 1'b1;
      rx_last  = (i == len - 1);
      if (i < hdr_words) rx_data = hdr[i*stream_w +: stream_w];
      else if (i == hdr_words) rx_data = m;
      else rx_data = $random(seed);  // filler words
    end
    @(posedge clk);
    #1;
    rx_valid = 1'b0;
    rx_last  = 1'b0;
  endtask

  task automatic trigger_case(input string what, input logic [hdr_words*stream_w-1:0] hdr,
                              input int len, input int want);
    int base;
    base = trig_seen;
    send_frame(hdr, len, 32'h0000_0001);
    repeat (3) @(negedge clk);
    check_count(what, want, trig_seen - base);
  endtask

  task automatic stall_case(input string what, input logic [hdr_words*stream_w-1:0] hdr,
                            input int m, input int want);
    int stalled;
    stalled = 0;
    send_frame(hdr, hdr_words + 1, 32'(m));
    repeat (m + 10) begin
      @(negedge clk);
      if (ext_stall) stalled++;
    end
    check_count(what, want, stalled);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int m;
    int total;
    arst_n       = 1'b0;
    retire_valid = 1'b0;
    pc           = '0;
    instr        = '0;
    trap         = 1'b0;
    gpr_wen      = 1'b0;
    gpr_addr     = '0;
    gpr_value    = '0;
    tx_ready     = 1'b1;
    rx_data      = '0;
    rx_valid     = 1'b0;
    rx_last      = 1'b0;
    start_test("reset");
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_count("{tx_valid,trigger,ext_stall}", 0, int'({tx_valid, trigger, ext_stall}));
    end_test();
    run_trace("trace_frames", 1'b0);
    run_trace("back_pressure", 1'b1);
    start_test("trigger");
    trigger_case("matching frame pulses", trigger_pattern, 7, 1);
    trigger_case("altered header pulses", trigger_pattern ^ (160'd1 << 70), 7, 0);
    trigger_case("five word frame pulses", trigger_pattern, 5, 0);
    end_test();
    start_test("slowdown");
    m = 1 + {$random(seed)} % 40;
    stall_case("stall cycles", slow_pattern, m, m);
    stall_case("zero stall cycles", slow_pattern, 0, 0);
    stall_case("trigger frame stall cycles", trigger_pattern, 25, 0);
    end_test();
    total = err_cnt + dut.checks.fail_cnt;
    $display("tests %0d, errors %0d, of which %0d from assertions", test_cnt, total,
             dut.checks.fail_cnt);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (run_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", run_cycles);
    $display("test failed");
    $finish;
  end

endmodule

// File: tb.f
common/trace_pkg.sv
trace/trace_capture.sv
trace/trace_packetizer.sv
host/frame_matcher.sv
host/host_stall_timer.sv
verilog/trace_link_top.sv
bench/trace_link_assertions.sv
bench/tb_top.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_top
FILELIST  = tb.f
RUN_ARGS  = +verilator+error+limit+1000
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = test failed
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
